// File: color_pkg.sv
package color_pkg;

   // table and field sizes
   localparam int VID_W    = 6;   // 64 vertices
   localparam int EDGE_W   = 8;   // 256 adjacency entries
   localparam int DEG_W    = 8;
   localparam int COLOR_W  = 6;
   localparam int ARGS_W   = 20;
   localparam int WB_ADR_W = 10;  // top bit picks the adjacency region

   localparam int PALETTE_N       = 32;  // colours tracked in the used bitmap
   localparam int COLOR_EXHAUSTED = 32;  // no free colour left

   localparam logic [COLOR_W-1:0] COLOR_NONE = 6'd63;

   // task types
   localparam logic [1:0] TT_SEND_DEGREE = 2'd1;
   localparam logic [1:0] TT_RECV_DEGREE = 2'd2;
   localparam logic [1:0] TT_RECV_COLOR  = 2'd3;

   typedef struct packed {
      logic [VID_W-1:0]              sender;
      logic [DEG_W-1:0]              degree;
      logic [ARGS_W-VID_W-DEG_W-1:0] rsvd;
   } deg_args_t;

   typedef struct packed {
      logic [VID_W-1:0]                sender;
      logic [COLOR_W-1:0]              color;
      logic [ARGS_W-VID_W-COLOR_W-1:0] rsvd;
   } clr_args_t;

   // sender sits in the same bits in both views
   typedef union packed {
      deg_args_t deg;
      clr_args_t clr;
   } color_args_u;

   typedef struct packed {
      logic [1:0]       task_type;
      logic [VID_W-1:0] locale;  // target vertex
      color_args_u      args;
   } color_task_t;

   typedef struct packed {
      logic [EDGE_W-1:0]    eo_begin;
      logic [DEG_W-1:0]     degree;
      logic [DEG_W-1:0]     degrees_pending;
      logic [DEG_W-1:0]     colors_pending;
      logic [PALETTE_N-1:0] used;
      logic [COLOR_W-1:0]   color;
   } vertex_rec_t;

   typedef struct packed {
      logic              is_color;  // 0 for a degree broadcast
      logic [VID_W-1:0]  src;
      logic [EDGE_W-1:0] eo_begin;
      logic [DEG_W-1:0]  degree;
      logic [DEG_W-1:0]  value;
   } bcast_t;

   typedef struct packed {
      logic                cyc;
      logic                stb;
      logic                we;
      logic [WB_ADR_W-1:0] adr;
      logic [31:0]         dat;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic              en;
      logic [VID_W-1:0]  vid;
      logic [EDGE_W-1:0] eo_begin;
      logic [DEG_W-1:0]  degree;
   } vtx_wr_t;

   typedef struct packed {
      logic              en;
      logic [EDGE_W-1:0] addr;
      logic [VID_W-1:0]  vid;
   } adj_wr_t;

endpackage

// File: graph_host_port.sv
module graph_host_port (
   input  logic                  clk,
   input  logic                  rstn,
   input  color_pkg::wb_req_t    wb_req,
   output color_pkg::wb_rsp_t    wb_rsp,
   output color_pkg::vtx_wr_t    vtx_wr,
   output color_pkg::adj_wr_t    adj_wr,
   input  color_pkg::vertex_rec_t vtx_rd
);
   import color_pkg::*;

   logic        req;
   logic        first;     // request seen, not yet acked
   logic        adj_region;
   logic        wr;
   logic        ack_q;
   logic [31:0] rd_q;
   logic [31:0] rd_word;

   assign req        = wb_req.cyc & wb_req.stb;
   assign first      = req & ~ack_q;
   assign adj_region = wb_req.adr[WB_ADR_W-1];
   assign wr         = first & wb_req.we;

   // table write strobes last one cycle
   always_comb begin
      vtx_wr.en       = wr & ~adj_region;
      vtx_wr.vid      = wb_req.adr[VID_W-1:0];
      vtx_wr.eo_begin = wb_req.dat[15:8];
      vtx_wr.degree   = wb_req.dat[7:0];

      adj_wr.en   = wr & adj_region;
      adj_wr.addr = wb_req.adr[EDGE_W-1:0];
      adj_wr.vid  = wb_req.dat[VID_W-1:0];
   end

   // colour, degrees pending, colours pending
   always_comb begin
      rd_word        = '0;
      rd_word[23:16] = vtx_rd.colors_pending;
      rd_word[15:8]  = vtx_rd.degrees_pending;
      rd_word[COLOR_W-1:0] = vtx_rd.color;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= first;
      end
   end

   always_ff @(posedge clk) begin
      if (first) begin
         rd_q <= adj_region ? 32'd0 : rd_word;  // adjacency region reads as zero
      end
   end

   assign wb_rsp.ack = ack_q;
   assign wb_rsp.dat = rd_q;

endmodule

// File: vertex_update.sv
module vertex_update (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          task_in_valid,
   output logic                          task_in_ready,
   input  color_pkg::color_task_t        task_in,
   input  color_pkg::vtx_wr_t            vtx_wr,
   input  logic [color_pkg::VID_W-1:0]   rd_vid,
   output color_pkg::vertex_rec_t        vtx_rd,
   output logic                          bc_valid,
   input  logic                          bc_ready,
   output color_pkg::bcast_t             bc
);
   import color_pkg::*;

   vertex_rec_t mem [2**VID_W];

   vertex_rec_t      cur;
   vertex_rec_t      nxt;
   vertex_rec_t      load_rec;
   bcast_t           bc_d;
   bcast_t           bc_q;
   logic             bc_valid_q;
   logic             accept;
   logic             do_bc;
   logic             settle;
   logic             prio;
   logic [VID_W-1:0] sid;
   logic [DEG_W-1:0] sdeg;

   function automatic logic [COLOR_W-1:0] lowest_free(input logic [PALETTE_N-1:0] used);
      logic [COLOR_W-1:0] c;
      c = COLOR_W'(COLOR_EXHAUSTED);
      for (int i = PALETTE_N - 1; i >= 0; i--) begin
         if (!used[i]) begin
            c = COLOR_W'(i);
         end
      end
      return c;
   endfunction

   assign task_in_ready = ~bc_valid_q | bc_ready;
   assign accept        = task_in_valid & task_in_ready;

   assign cur = mem[task_in.locale];
   assign sid = task_in.args.deg.sender;

   // colour tasks carry no degree, take it from the sender's own record
   assign sdeg = (task_in.task_type == TT_RECV_DEGREE) ? task_in.args.deg.degree
                                                       : mem[sid].degree;

   // larger degree wins, lower id breaks a tie
   assign prio = (sdeg > cur.degree) ||
                 ((sdeg == cur.degree) && (sid < task_in.locale));

   always_comb begin
      nxt    = cur;
      do_bc  = 1'b0;
      settle = 1'b0;

      bc_d.is_color = 1'b1;
      bc_d.src      = task_in.locale;
      bc_d.eo_begin = cur.eo_begin;
      bc_d.degree   = cur.degree;
      bc_d.value    = '0;

      case (task_in.task_type)
         TT_SEND_DEGREE: begin
            if (cur.degree == '0) begin
               nxt.color = '0;  // isolated vertex
            end else begin
               do_bc         = 1'b1;
               bc_d.is_color = 1'b0;
               bc_d.value    = cur.degree;
            end
         end
         TT_RECV_DEGREE: begin
            nxt.degrees_pending = cur.degrees_pending - 1'b1;
            if (prio) begin
               nxt.colors_pending = cur.colors_pending + 1'b1;
            end
            settle = 1'b1;
         end
         TT_RECV_COLOR: begin
            if (prio) begin
               nxt.colors_pending = cur.colors_pending - 1'b1;
               nxt.used = cur.used | (PALETTE_N'(1) << task_in.args.clr.color);
               settle   = 1'b1;
            end
         end
         default: begin
         end
      endcase

      if (settle && (nxt.degrees_pending == '0) && (nxt.colors_pending == '0)) begin
         nxt.color  = lowest_free(nxt.used);
         do_bc      = 1'b1;
         bc_d.value = DEG_W'(nxt.color);
      end
   end

   // host load resets the whole record
   always_comb begin
      load_rec.eo_begin        = vtx_wr.eo_begin;
      load_rec.degree          = vtx_wr.degree;
      load_rec.degrees_pending = vtx_wr.degree;
      load_rec.colors_pending  = '0;
      load_rec.used            = '0;
      load_rec.color           = COLOR_NONE;
   end

   always_ff @(posedge clk) begin
      if (vtx_wr.en) begin
         mem[vtx_wr.vid] <= load_rec;
      end else if (accept) begin
         mem[task_in.locale] <= nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         bc_valid_q <= 1'b0;
      end else if (accept) begin
         bc_valid_q <= do_bc;
      end else if (bc_ready) begin
         bc_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         bc_q <= bc_d;
      end
   end

   assign bc_valid = bc_valid_q;
   assign bc       = bc_q;
   assign vtx_rd   = mem[rd_vid];

endmodule

// File: neighbor_fanout.sv
module neighbor_fanout (
   input  logic                   clk,
   input  logic                   rstn,
   input  color_pkg::adj_wr_t     adj_wr,
   input  logic                   bc_valid,
   output logic                   bc_ready,
   input  color_pkg::bcast_t      bc,
   output logic                   task_out_valid,
   input  logic                   task_out_ready,
   output color_pkg::color_task_t task_out
);
   import color_pkg::*;

   logic [VID_W-1:0] adj [2**EDGE_W];

   bcast_t            cur;
   logic              busy;
   logic [EDGE_W-1:0] idx;
   logic [DEG_W-1:0]  cnt;   // children still to send
   logic              last;
   logic              take_bc;
   logic              take_child;

   always_ff @(posedge clk) begin
      if (adj_wr.en) begin
         adj[adj_wr.addr] <= adj_wr.vid;
      end
   end

   assign last       = (cnt == DEG_W'(1));
   assign take_child = busy & task_out_ready;
   assign bc_ready   = ~busy | (last & task_out_ready);
   assign take_bc    = bc_valid & bc_ready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
      end else if (take_bc) begin
         busy <= (bc.degree != '0);
      end else if (take_child && last) begin
         busy <= 1'b0;
      end
   end

   // walk eo_begin .. eo_begin + degree - 1
   always_ff @(posedge clk) begin
      if (take_bc) begin
         cur <= bc;
         idx <= bc.eo_begin;
         cnt <= bc.degree;
      end else if (take_child) begin
         idx <= idx + 1'b1;
         cnt <= cnt - 1'b1;
      end
   end

   assign task_out_valid = busy;

   always_comb begin
      task_out        = '0;
      task_out.locale = adj[idx];
      if (cur.is_color) begin
         task_out.task_type      = TT_RECV_COLOR;
         task_out.args.clr.sender = cur.src;
         task_out.args.clr.color  = cur.value[COLOR_W-1:0];
      end else begin
         task_out.task_type       = TT_RECV_DEGREE;
         task_out.args.deg.sender = cur.src;
         task_out.args.deg.degree = cur.value;
      end
   end

endmodule

// File: color_core.sv
module color_core (
   input  logic                   clk,
   input  logic                   rstn,
   input  color_pkg::wb_req_t     wb_req,
   output color_pkg::wb_rsp_t     wb_rsp,
   input  logic                   task_in_valid,
   output logic                   task_in_ready,
   input  color_pkg::color_task_t task_in,
   output logic                   task_out_valid,
   input  logic                   task_out_ready,
   output color_pkg::color_task_t task_out
);
   import color_pkg::*;

   vtx_wr_t     vtx_wr;
   adj_wr_t     adj_wr;
   vertex_rec_t vtx_rd;
   bcast_t      bc;
   logic        bc_valid;
   logic        bc_ready;

   graph_host_port u_host (
      .clk    (clk),
      .rstn   (rstn),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp),
      .vtx_wr (vtx_wr),
      .adj_wr (adj_wr),
      .vtx_rd (vtx_rd)
   );

   vertex_update u_update (
      .clk           (clk),
      .rstn          (rstn),
      .task_in_valid (task_in_valid),
      .task_in_ready (task_in_ready),
      .task_in       (task_in),
      .vtx_wr        (vtx_wr),
      .rd_vid        (wb_req.adr[VID_W-1:0]),  // readback follows the bus address
      .vtx_rd        (vtx_rd),
      .bc_valid      (bc_valid),
      .bc_ready      (bc_ready),
      .bc            (bc)
   );

   neighbor_fanout u_fanout (
      .clk            (clk),
      .rstn           (rstn),
      .adj_wr         (adj_wr),
      .bc_valid       (bc_valid),
      .bc_ready       (bc_ready),
      .bc             (bc),
      .task_out_valid (task_out_valid),
      .task_out_ready (task_out_ready),
      .task_out       (task_out)
   );

endmodule

// File: tb_color_tasks.svh
`ifndef TB_COLOR_TASKS_SVH
`define TB_COLOR_TASKS_SVH

function automatic logic [31:0] xorshift32();
   rng ^= rng << 13;
   rng ^= rng >> 17;
   rng ^= rng << 5;
   return rng;
endfunction

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
   assert (act == exp) else begin
      errors++;
      $display("Error %s expected %0h actual %0h", name, exp, act);
   end
endtask

// one classic cycle, request held until ack
task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                         input logic [31:0] wdat, output logic [31:0] rdat);
   int n;
   @(posedge clk);
   wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
   n = 0;
   do begin
      @(negedge clk);
      n++;
   end while (!wb_rsp.ack && n < 16);
   if (!wb_rsp.ack) begin
      timeouts++;
      $display("no Wishbone ack at address %0h", adr);
   end else begin
      check_value("ack_latency", 2, n);  // ack on the cycle after the request
   end
   rdat = wb_rsp.dat;
   @(posedge clk);
   wb_req <= '0;
endtask

// higher degree first, lower id on a tie
function automatic logic outranks(input int s, input int v);
   return (deg[s] > deg[v]) || ((deg[s] == deg[v]) && (s < v));
endfunction

// greedy pass in priority order
function automatic void model_colors();
   logic        done [2**VID_W];
   logic [31:0] used;
   int          best;
   int          c;
   for (int v = 0; v < n_vtx; v++) begin
      done[v] = 1'b0;
   end
   for (int k = 0; k < n_vtx; k++) begin
      best = -1;
      for (int v = 0; v < n_vtx; v++) begin
         if (!done[v] && (best < 0 || outranks(v, best))) begin
            best = v;
         end
      end
      used = '0;
      for (int i = 0; i < deg[best]; i++) begin
         if (done[adj_m[eo[best] + i]]) begin
            used[ref_color[adj_m[eo[best] + i]]] = 1'b1;
         end
      end
      c = 0;
      while (c < 32 && used[c]) begin
         c++;
      end
      ref_color[best] = c;  // 32 when the palette is full
      done[best]      = 1'b1;
   end
endfunction

child_held: assert property (@(posedge clk) disable iff (!rstn)
   (task_out_valid && !task_out_ready) |=> (task_out_valid && $stable(task_out)))
   else begin
      errors++;
      $display("task_out changed or vanished while it waited for ready");
   end

ack_pulse: assert property (@(posedge clk) disable iff (!rstn) wb_rsp.ack |=> !wb_rsp.ack)
   else begin
      errors++;
      $display("Wishbone ack stayed high for more than one cycle");
   end

`endif

// File: tb_color_core.sv
module tb_color_core;
   import color_pkg::*;

   logic        clk;
   logic        rstn;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   logic        task_in_valid;
   logic        task_in_ready;
   color_task_t task_in;
   logic        task_out_valid;
   logic        task_out_ready;
   color_task_t task_out;

   int          errors = 0;
   int          timeouts = 0;
   logic [31:0] rng = 32'd18197;
   logic        rand_ready = 1'b0;
   logic        feedback = 1'b0;
   int          n_vtx = 8;  // vertex 7 has no edges
   int          edges [20] = '{0, 1, 0, 2, 1, 2, 1, 3, 2, 3, 3, 4, 4, 5, 5, 6, 4, 6, 2, 4};
   int          deg [2**VID_W];
   int          eo [2**VID_W];
   int          adj_m [2**EDGE_W];
   int          ref_color [2**VID_W];
   int          dut_color [2**VID_W];
   color_task_t feed [$];
   color_task_t seen [$];
   color_task_t first_seen [$];

   `include "tb_color_tasks.svh"

   color_core UUT (
      .clk            (clk),
      .rstn           (rstn),
      .wb_req         (wb_req),
      .wb_rsp         (wb_rsp),
      .task_in_valid  (task_in_valid),
      .task_in_ready  (task_in_ready),
      .task_in        (task_in),
      .task_out_valid (task_out_valid),
      .task_out_ready (task_out_ready),
      .task_out       (task_out)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      logic [31:0] r;
      forever begin
         @(posedge clk);
         r = xorshift32();
         task_out_ready <= rand_ready ? r[0] : 1'b1;
      end
   end

   // a child seen here is taken at the next rising edge
   initial begin
      forever begin
         @(negedge clk);
         if (task_out_valid && task_out_ready) begin
            seen.push_back(task_out);
            if (feedback) feed.push_back(task_out);
         end
      end
   end

   function automatic color_task_t send_degree_task(input int v);
      color_task_t t;
      t           = '0;
      t.task_type = TT_SEND_DEGREE;
      t.locale    = VID_W'(v);
      return t;
   endfunction

   // build CSR from the edge list and write it through the host port
   task automatic load_graph();
      logic [31:0] unused_rd;
      int          p;
      p = 0;
      for (int v = 0; v < n_vtx; v++) begin
         eo[v]  = p;
         deg[v] = 0;
         for (int e = 0; e < $size(edges); e += 2) begin
            if (edges[e] == v || edges[e+1] == v) begin
               adj_m[p] = (edges[e] == v) ? edges[e+1] : edges[e];
               p++;
               deg[v]++;
            end
         end
         wb_access(1'b1, WB_ADR_W'(v), {16'd0, 8'(eo[v]), 8'(deg[v])}, unused_rd);
      end
      for (int i = 0; i < p; i++) begin
         wb_access(1'b1, WB_ADR_W'(2**(WB_ADR_W-1) + i), 32'(adj_m[i]), unused_rd);
      end
   endtask

   task automatic read_vertex(input int v, output logic [31:0] word);
      wb_access(1'b0, WB_ADR_W'(v), 32'd0, word);
   endtask

   task automatic send_task(input color_task_t t);
      int n;
      @(posedge clk);
      task_in_valid <= 1'b1;
      task_in       <= t;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!task_in_ready && n < 100);
      if (!task_in_ready) begin
         timeouts++;
         $display("task_in_ready stayed low, task not accepted");
      end
      @(posedge clk);
      task_in_valid <= 1'b0;
   endtask

   // feed the queue until the pipeline sits idle
   task automatic run_tasks();
      int idle;
      int n;
      idle = 0;
      n    = 0;
      while (idle < 4 && n < 4000) begin
         if (feed.size() > 0) begin
            send_task(feed.pop_front());
            idle = 0;
         end else begin
            @(negedge clk);
            idle = task_out_valid ? 0 : idle + 1;
         end
         n++;
      end
      if (idle < 4) begin
         timeouts++;
         $display("task pipeline did not drain");
      end
   endtask

   initial begin
      logic [31:0] rd;
      color_task_t exp_t;
      int          hits;
      int          u;
      logic        top;
      rstn           = 1'b0;
      wb_req         = '0;
      task_in_valid  = 1'b0;
      task_in        = '0;
      task_out_ready = 1'b1;
      repeat (2) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);
      check_value("reset_out_valid", 0, 32'(task_out_valid));
      check_value("reset_bc_valid", 0, 32'(UUT.u_update.bc_valid));
      check_value("reset_ack", 0, 32'(wb_rsp.ack));
      check_value("reset_in_ready", 1, 32'(task_in_ready));

      load_graph();
      for (int v = 0; v < n_vtx; v++) begin
         read_vertex(v, rd);
         check_value("load_color", 32'(COLOR_NONE), 32'(rd[5:0]));
         check_value("load_deg_pending", deg[v], 32'(rd[15:8]));
         check_value("load_clr_pending", 0, 32'(rd[23:16]));
      end

      // send-degree fanout with ready held high
      for (int v = 0; v < n_vtx; v++) feed.push_back(send_degree_task(v));
      run_tasks();
      hits = 0;
      for (int v = 0; v < n_vtx; v++) begin
         for (int i = 0; i < deg[v]; i++) begin
            exp_t                 = '0;
            exp_t.task_type       = TT_RECV_DEGREE;
            exp_t.locale          = VID_W'(adj_m[eo[v] + i]);
            exp_t.args.deg.sender = VID_W'(v);
            exp_t.args.deg.degree = DEG_W'(deg[v]);
            if (hits < seen.size()) check_value("fanout_child", 32'(exp_t), 32'(seen[hits]));
            hits++;
         end
         if (deg[v] == 0) begin
            read_vertex(v, rd);
            check_value("isolated_color", 0, 32'(rd[5:0]));
         end
      end
      check_value("fanout_count", hits, seen.size());

      // same tasks again under random back-pressure
      first_seen = seen;
      seen.delete();
      rand_ready = 1'b1;
      for (int v = 0; v < n_vtx; v++) feed.push_back(send_degree_task(v));
      run_tasks();
      check_value("backpressure_count", first_seen.size(), seen.size());
      for (int i = 0; i < first_seen.size() && i < seen.size(); i++) begin
         check_value("backpressure_child", 32'(first_seen[i]), 32'(seen[i]));
      end

      // full run, every child goes back in
      load_graph();
      model_colors();
      seen.delete();
      feedback = 1'b1;
      for (int v = 0; v < n_vtx; v++) feed.push_back(send_degree_task(v));
      run_tasks();
      feedback = 1'b0;
      check_value("feedback_count", 2 * $size(edges), seen.size());

      for (int v = 0; v < n_vtx; v++) begin
         read_vertex(v, rd);
         dut_color[v] = 32'(rd[5:0]);
         check_value("final_color", ref_color[v], 32'(rd[5:0]));
         check_value("final_deg_pending", 0, 32'(rd[15:8]));
         check_value("final_clr_pending", 0, 32'(rd[23:16]));
      end
      for (int v = 0; v < n_vtx; v++) begin
         top = 1'b1;
         for (int i = 0; i < deg[v]; i++) begin
            u = adj_m[eo[v] + i];
            if (outranks(u, v)) top = 1'b0;
            check_value("adjacent_distinct", 1, 32'(dut_color[v] != dut_color[u]));
         end
         if (top && deg[v] > 0) begin
            hits = 0;
            for (int k = 0; k < seen.size(); k++) begin
               exp_t = seen[k];
               if (exp_t.task_type == TT_RECV_COLOR && exp_t.args.clr.sender == VID_W'(v) &&
                   exp_t.args.clr.color == '0) hits++;
            end
            check_value("local_max_bcast", deg[v], hits);
            check_value("local_max_color", 0, dut_color[v]);
         end
      end

      $display("checks done, errors %0d timeouts %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: list.f
+incdir+.
color_pkg.sv
graph_host_port.sv
vertex_update.sv
neighbor_fanout.sv
color_core.sv
tb_color_core.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_color_core -f list.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_color_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
   exit 0
fi
exit 1
